// File: Makefile
# Verilator simulation of the firing controller

VERILATOR ?= verilator
TOP       ?= fire_ctrl_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
+incdir+source
source/fire_cmd_pkg.sv
source/fire_chan_pkg.sv
source/command_fsm.sv
source/pre_power_monitor.sv
source/fire_timer.sv
source/channel_sequencer.sv
source/decoder_driver.sv
source/fire_ctrl_top.sv
tests/fire_ctrl_tb.sv

// File: source/channel_sequencer.sv
//--------------------
// channel sequencer
// walks the enable mask lowest channel first, keeps done flags
//--------------------
`include "fire_macros.svh"

module channel_sequencer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       load,
	input  logic [31:0]                cmd_param,
	input  logic                       timer_done,
	input  logic                       timer_on,
	output logic                       start,
	output fire_cmd_pkg::fire_exp_t    fire_exp,
	output fire_chan_pkg::chan_t       chan,
	output logic                       chan_on,
	output logic                       busy,
	output fire_chan_pkg::chan_mask_t  done_flags
);
	import fire_chan_pkg::*;

	chan_mask_t pending;
	chan_t      pick;
	logic       running;

	// lowest pending channel wins
	always_comb begin
		pick = '0;
		for (int i = `FIRE_CHANNELS - 1; i >= 0; i--) begin
			if (pending[i])
				pick = chan_t'(i);
		end
	end

	assign busy = (|pending) || timer_on;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending    <= '0;
			done_flags <= '0;
			running    <= 1'b0;
			start      <= 1'b0;
			chan_on    <= 1'b0;
		end else begin
			start   <= 1'b0;
			chan_on <= timer_on;  // aligned with chan
			if (load) begin
				pending    <= cmd_param[`FIRE_CHANNELS-1:0];
				done_flags <= done_flags & ~cmd_param[`FIRE_CHANNELS-1:0];
			end else if (timer_done) begin
				pending[chan]    <= 1'b0;
				done_flags[chan] <= 1'b1;
				running          <= 1'b0;
			end else if (!running && |pending) begin
				start   <= 1'b1;
				running <= 1'b1;
			end
		end
	end

	// payload, held for the whole round or channel
	always_ff @(posedge clk) begin
		if (load)
			fire_exp <= cmd_param[25:24];
		if (!load && !timer_done && !running && |pending)
			chan <= pick;
	end

endmodule

// File: source/command_fsm.sv
//--------------------
// controller FSM: idle, pre-power and firing
// owns pre-power status and the error code
//--------------------
`include "fire_macros.svh"

module command_fsm (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cmd_ready,
	input  fire_cmd_pkg::cmd_code_t cmd_type,
	input  logic                    pre_ok,
	input  logic                    pre_fail,
	input  logic                    seq_busy,
	output logic                    powering,
	output logic                    pre_pwr_on,
	output logic                    load,
	output logic                    pre_status,
	output fire_cmd_pkg::err_code_t err_code
);
	import fire_cmd_pkg::*;

	ctrl_state_e state;
	logic        is_pre;
	logic        is_explode;
	logic        is_cancel;

	assign is_pre     = cmd_ready && (cmd_type == CMD_PRE_POWER);
	assign is_explode = cmd_ready && (cmd_type == CMD_EXPLODE);
	assign is_cancel  = cmd_ready && (cmd_type == CMD_CANCEL);

	// explode only after pre-power has succeeded
	assign load = (state == PRE_POWER) && pre_status && is_explode && !pre_fail;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			powering   <= 1'b0;
			pre_pwr_on <= 1'b0;
			pre_status <= 1'b0;
			err_code   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (is_pre) begin
						state      <= PRE_POWER;
						powering   <= 1'b1;
						pre_pwr_on <= 1'b1;
					end
				end
				PRE_POWER: begin
					if (is_cancel || pre_fail) begin
						state      <= IDLE;
						powering   <= 1'b0;
						pre_pwr_on <= 1'b0;
						pre_status <= 1'b0;
						if (pre_fail)
							err_code <= err_code_t'(`ERR_PRE_POWER_FAIL);  // sticky
					end else if (load) begin
						state    <= FIRING;
						powering <= 1'b0;  // monitor rests while firing
					end else if (pre_ok) begin
						pre_status <= 1'b1;
					end
				end
				FIRING: begin
					if (!seq_busy) begin
						state      <= IDLE;
						pre_pwr_on <= 1'b0;
						pre_status <= 1'b0;  // next round needs a fresh pre-power
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// armed load still has the monitor's success and an idle sequencer
	a_load_armed: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> pre_ok && !seq_busy)
		else $error("load without pre-power success or while sequencer busy");

endmodule

// File: source/decoder_driver.sv
//--------------------
// drives the 4-to-16 and 2-to-4 decoders
// staged enable and strobe per channel bank
//--------------------
`include "fire_macros.svh"

module decoder_driver (
	input  logic                    clk,
	input  logic                    rst_n,
	input  fire_chan_pkg::chan_t    chan,
	input  logic                    chan_on,
	output fire_chan_pkg::lo_addr_t cd4514_d,
	output logic                    cd4514_strobe,
	output logic                    cd4514_en_n,
	output fire_chan_pkg::hi_addr_t cd4555_d,
	output logic                    cd4555_en_n
);
	import fire_chan_pkg::*;

	logic [`STROBE_DELAY-2:0] stage;  // cycles since chan_on rose
	logic                     lo_bank;
	logic                     hi_bank;

	assign lo_bank = chan < chan_t'(`FIRE_LO_CHANNELS);
	assign hi_bank = !lo_bank && (chan < chan_t'(`FIRE_CHANNELS));

	always_ff @(posedge clk) begin
		if (!rst_n || !chan_on) begin
			stage         <= '0;
			cd4514_d      <= '0;
			cd4514_strobe <= 1'b0;
			cd4514_en_n   <= 1'b1;
			cd4555_d      <= '0;
			cd4555_en_n   <= 1'b1;
		end else begin
			stage <= {stage[`STROBE_DELAY-3:0], 1'b1};

			// --------------------
			// channels 0..15
			cd4514_d      <= lo_bank ? lo_addr_t'(chan) : '0;
			cd4514_en_n   <= !(lo_bank && stage[`ENABLE_DELAY-2]);
			cd4514_strobe <= lo_bank && stage[`STROBE_DELAY-2];  // latch address

			// --------------------
			// channels 16..19
			cd4555_d    <= hi_bank ? hi_addr_t'(chan) : '0;
			cd4555_en_n <= !(hi_bank && stage[`ENABLE_DELAY-2]);
		end
	end

	a_one_bank: assert property (@(posedge clk) disable iff (!rst_n)
		!(!cd4514_en_n && !cd4555_en_n))
		else $error("both decoder enables active");

endmodule

// File: source/fire_chan_pkg.sv
//--------------------
// channel index, channel mask and decoder address types
//--------------------
`include "fire_macros.svh"

package fire_chan_pkg;

	typedef logic [4:0] chan_t;  // 0..19

	typedef logic [`FIRE_CHANNELS-1:0] chan_mask_t;  // one bit per channel

	typedef logic [3:0] lo_addr_t;  // 4-to-16 decoder input
	typedef logic [1:0] hi_addr_t;  // 2-to-4 decoder input

endpackage

// File: source/fire_cmd_pkg.sv
//--------------------
// command codes, command fields and controller state
//--------------------
package fire_cmd_pkg;

	typedef logic [7:0] cmd_code_t;

	localparam cmd_code_t CMD_EXPLODE   = 8'h05;
	localparam cmd_code_t CMD_CANCEL    = 8'h06;
	localparam cmd_code_t CMD_PRE_POWER = 8'h07;

	typedef logic [1:0] fire_exp_t;  // on-time = base << exp
	typedef logic [7:0] err_code_t;

	typedef enum logic [1:0] {
		IDLE,
		PRE_POWER,
		FIRING
	} ctrl_state_e;

endpackage

// File: source/fire_ctrl_top.sv
//--------------------
// firing controller top
// wires FSM, monitor, sequencer, timer and decoder driver
//--------------------
`include "fire_macros.svh"

module fire_ctrl_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cmd_ready,
	input  fire_cmd_pkg::cmd_code_t cmd_type,
	input  logic [31:0]             cmd_param,
	input  logic                    pre_pwr_on_ack,
	output logic                    pre_pwr_on,
	output fire_chan_pkg::lo_addr_t cd4514_d,
	output logic                    cd4514_strobe,
	output logic                    cd4514_en_n,
	output fire_chan_pkg::hi_addr_t cd4555_d,
	output logic                    cd4555_en_n,
	output logic [31:0]             fire_status,
	output fire_cmd_pkg::err_code_t err_code
);
	import fire_cmd_pkg::*;
	import fire_chan_pkg::*;

	logic       powering;
	logic       pre_ok;
	logic       pre_fail;
	logic       load;
	logic       pre_status;
	logic       seq_busy;
	logic       start;
	logic       timer_on;
	logic       timer_done;
	logic       chan_on;
	fire_exp_t  fire_exp;
	chan_t      chan;
	chan_mask_t done_flags;

	// bit 31 pre-power ok, low bits per-channel done
	assign fire_status = {pre_status, {(31 - `FIRE_CHANNELS){1'b0}}, done_flags};

	command_fsm u_fsm (
		.clk(clk), .rst_n(rst_n),
		.cmd_ready(cmd_ready), .cmd_type(cmd_type),
		.pre_ok(pre_ok), .pre_fail(pre_fail), .seq_busy(seq_busy),
		.powering(powering), .pre_pwr_on(pre_pwr_on), .load(load),
		.pre_status(pre_status), .err_code(err_code)
	);

	pre_power_monitor u_mon (
		.clk(clk), .rst_n(rst_n),
		.powering(powering), .pre_pwr_on_ack(pre_pwr_on_ack),
		.pre_ok(pre_ok), .pre_fail(pre_fail)
	);

	channel_sequencer u_seq (
		.clk(clk), .rst_n(rst_n),
		.load(load), .cmd_param(cmd_param),
		.timer_done(timer_done), .timer_on(timer_on),
		.start(start), .fire_exp(fire_exp), .chan(chan), .chan_on(chan_on),
		.busy(seq_busy), .done_flags(done_flags)
	);

	fire_timer u_timer (
		.clk(clk), .rst_n(rst_n),
		.start(start), .fire_exp(fire_exp),
		.chan_on(timer_on), .done(timer_done)
	);

	decoder_driver u_dec (
		.clk(clk), .rst_n(rst_n),
		.chan(chan), .chan_on(chan_on),
		.cd4514_d(cd4514_d), .cd4514_strobe(cd4514_strobe), .cd4514_en_n(cd4514_en_n),
		.cd4555_d(cd4555_d), .cd4555_en_n(cd4555_en_n)
	);

endmodule

// File: source/fire_macros.svh
//--------------------
// firing controller timing and width macros
// all cycle counts are in clk periods
//--------------------
`ifndef FIRE_MACROS_SVH
`define FIRE_MACROS_SVH

`define FIRE_CHANNELS       20  // total firing channels
`define FIRE_LO_CHANNELS    16  // channels on the 4-to-16 decoder
`define PRE_GUARD_CYCLES    40  // low ack cycles for pre-power success
`define PRE_FAIL_CYCLES     60  // pre-power timeout
`define PRE_CNT_W           7   // guard and fail counter width
`define FIRE_BASE_CYCLES    16  // on-time at exponent 0
`define FIRE_GAP_CYCLES     6   // idle gap after each channel
`define FIRE_CNT_W          8   // holds max on-time plus gap
`define ENABLE_DELAY        2   // select to decoder enable
`define STROBE_DELAY        5   // select to strobe
`define ERR_PRE_POWER_FAIL  1

`endif

// File: source/fire_timer.sv
//--------------------
// per-channel on-time window and guard gap
//--------------------
`include "fire_macros.svh"

module fire_timer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  fire_cmd_pkg::fire_exp_t fire_exp,
	output logic                    chan_on,
	output logic                    done
);
	logic [`FIRE_CNT_W-1:0] cnt;
	logic [`FIRE_CNT_W-1:0] on_len;
	logic                   active;

	assign on_len = `FIRE_CNT_W'(`FIRE_BASE_CYCLES) << fire_exp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt     <= '0;
			active  <= 1'b0;
			chan_on <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				cnt     <= '0;
				active  <= 1'b1;
				chan_on <= 1'b1;
			end else if (active) begin
				cnt     <= cnt + 1'b1;
				chan_on <= (cnt + 1'b1 < on_len);  // on window, then gap
				if (cnt == on_len + `FIRE_CNT_W'(`FIRE_GAP_CYCLES) - 1'b1) begin
					active <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !active)
		else $error("start while timer running");

endmodule

// File: source/pre_power_monitor.sv
//--------------------
// pre-power acknowledge monitor
// guard counter for success, fail counter for timeout
//--------------------
`include "fire_macros.svh"

module pre_power_monitor (
	input  logic clk,
	input  logic rst_n,
	input  logic powering,
	input  logic pre_pwr_on_ack,
	output logic pre_ok,
	output logic pre_fail
);
	logic [1:0]            ack_sync;
	logic                  ack_low;
	logic [`PRE_CNT_W-1:0] guard_cnt;
	logic [`PRE_CNT_W-1:0] guard_next;
	logic [`PRE_CNT_W-1:0] fail_cnt;

	assign ack_low    = !ack_sync[1];  // ack is active low
	assign guard_next = (ack_low && guard_cnt < `PRE_GUARD_CYCLES) ?
		guard_cnt + 1'b1 : guard_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n)
			ack_sync <= 2'b11;
		else
			ack_sync <= {ack_sync[0], pre_pwr_on_ack};
	end

	always_ff @(posedge clk) begin
		if (!rst_n || !powering) begin
			guard_cnt <= '0;
			fail_cnt  <= '0;
			pre_ok    <= 1'b0;
			pre_fail  <= 1'b0;
		end else begin
			guard_cnt <= guard_next;
			pre_ok    <= (guard_next == `PRE_GUARD_CYCLES);  // saturated
			pre_fail  <= 1'b0;
			if (!pre_ok && fail_cnt <= `PRE_FAIL_CYCLES) begin
				fail_cnt <= fail_cnt + 1'b1;
				// single pulse as the count passes the limit
				pre_fail <= (fail_cnt == `PRE_FAIL_CYCLES) &&
					(guard_next != `PRE_GUARD_CYCLES);
			end
		end
	end

	a_fail_excl: assert property (@(posedge clk) disable iff (!rst_n)
		pre_fail |-> !pre_ok ##1 !pre_fail)
		else $error("pre_fail overlaps pre_ok or repeats");

endmodule

// File: tests/fire_ctrl_tb.sv
//--------------------
// firing controller testbench
// LCG explode rounds checked against a reference model
//--------------------
`include "fire_macros.svh"

module fire_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fire_cmd_pkg::*;
	import fire_chan_pkg::*;

	localparam int ROUNDS     = 4;
	localparam int SEL_STATUS = 0;  // fire_status[31]
	localparam int SEL_PWR    = 1;  // pre_pwr_on
	localparam int SEL_ERR    = 2;  // err_code nonzero

	logic        clk = 1'b0;
	logic        rst_n;
	logic        cmd_ready;
	cmd_code_t   cmd_type;
	logic [31:0] cmd_param;
	logic        pre_pwr_on_ack;
	logic        pre_pwr_on;
	lo_addr_t    cd4514_d;
	logic        cd4514_strobe;
	logic        cd4514_en_n;
	hi_addr_t    cd4555_d;
	logic        cd4555_en_n;
	logic [31:0] fire_status;
	err_code_t   err_code;

	int          errors = 0;
	int          checks = 0;
	int          fired[$];           // channels seen by the monitor
	int          expected_chans[$];  // from the reference model
	int          round_base = 0;
	int          strobe_rises = 0;
	int          strobe_base = 0;
	logic        prev_en_lo = 1'b1;
	logic        prev_en_hi = 1'b1;
	logic        prev_strobe = 1'b0;
	logic [31:0] exp_status;
	logic [31:0] seed;
	logic [31:0] param;
	logic [`FIRE_CHANNELS-1:0] prev_flags;
	event        check_round;

	fire_ctrl_top dut0 (
		.clk(clk), .rst_n(rst_n),
		.cmd_ready(cmd_ready), .cmd_type(cmd_type), .cmd_param(cmd_param),
		.pre_pwr_on_ack(pre_pwr_on_ack), .pre_pwr_on(pre_pwr_on),
		.cd4514_d(cd4514_d), .cd4514_strobe(cd4514_strobe), .cd4514_en_n(cd4514_en_n),
		.cd4555_d(cd4555_d), .cd4555_en_n(cd4555_en_n),
		.fire_status(fire_status), .err_code(err_code)
	);

	always #10 clk = ~clk;  // 20 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected status after a round, fills the ascending channel list
	function automatic logic [31:0] ref_round(input logic [`FIRE_CHANNELS-1:0] flags,
		input logic [`FIRE_CHANNELS-1:0] mask);
		logic [31:0] status;
		expected_chans.delete();
		for (int i = 0; i < `FIRE_CHANNELS; i++)
			if (mask[i])
				expected_chans.push_back(i);
		status = '0;
		status[`FIRE_CHANNELS-1:0] = flags | mask;  // bit 31 drops after firing
		return status;
	endfunction

	function automatic logic sig_value(input int sel);
		case (sel)
			SEL_STATUS: return fire_status[31];
			SEL_PWR:    return pre_pwr_on;
			default:    return err_code != '0;
		endcase
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("Fail at %0d ns: %s", $time, msg);
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
			report_fail($sformatf("%s is %0h, expected %0h", what, got, exp));
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	task automatic wait_signal(input int sel, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (sig_value(sel) !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (sig_value(sel) !== level) begin
			errors++;
			$display("timeout while waiting for %s", what);
			finish_run();
		end
	endtask

	task automatic send_cmd(input cmd_code_t code, input logic [31:0] p);
		@(posedge clk);
		#2;
		cmd_ready = 1'b1;
		cmd_type  = code;
		cmd_param = p;
		@(posedge clk);
		#2;
		cmd_ready = 1'b0;
		cmd_type  = '0;
		cmd_param = '0;
	endtask

	// --------------------
	// decoder monitor
	always @(negedge clk) begin
		if (rst_n) begin
			if (!cd4514_en_n && !cd4555_en_n)
				report_fail("both decoder enables low");
			if (cd4514_strobe && cd4514_en_n)
				report_fail("strobe without 4-to-16 enable");
			if (prev_en_lo && !cd4514_en_n)
				fired.push_back(int'(cd4514_d));
			if (prev_en_hi && !cd4555_en_n)
				fired.push_back(`FIRE_LO_CHANNELS + int'(cd4555_d));
			if (!prev_strobe && cd4514_strobe)
				strobe_rises++;
		end
		prev_en_lo  = cd4514_en_n;
		prev_en_hi  = cd4555_en_n;
		prev_strobe = cd4514_strobe;
	end

	// --------------------
	// round compare
	always begin
		int n;
		int lo;
		@(check_round);
		n  = fired.size() - round_base;
		lo = 0;
		check_value("fired channel count", n, expected_chans.size());
		foreach (expected_chans[i]) begin
			if (expected_chans[i] < `FIRE_LO_CHANNELS)
				lo++;
			if (i < n)
				check_value($sformatf("firing %0d channel", i), fired[round_base + i],
					expected_chans[i]);
		end
		check_value("strobe count", strobe_rises - strobe_base, lo);
		check_value("fire_status", fire_status, exp_status);
		round_base  = fired.size();
		strobe_base = strobe_rises;
	end

	initial begin
		rst_n          = 1'b0;
		cmd_ready      = 1'b0;
		cmd_type       = '0;
		cmd_param      = '0;
		pre_pwr_on_ack = 1'b1;  // not acknowledged
		seed           = 32'he072;
		prev_flags     = '0;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;

		@(negedge clk);
		check_value("pre_pwr_on after reset", pre_pwr_on, 0);
		check_value("strobe after reset", cd4514_strobe, 0);
		check_value("cd4514_en_n after reset", cd4514_en_n, 1);
		check_value("cd4555_en_n after reset", cd4555_en_n, 1);
		check_value("cd4514_d after reset", cd4514_d, 0);
		check_value("cd4555_d after reset", cd4555_d, 0);
		check_value("fire_status after reset", fire_status, 0);
		check_value("err_code after reset", err_code, 0);

		// ack never arrives
		send_cmd(CMD_PRE_POWER, '0);
		wait_signal(SEL_PWR, 1'b1, 5, "pre_pwr_on to rise");
		wait_signal(SEL_ERR, 1'b1, 200, "the pre-power failure");
		check_value("err_code after failure", err_code, `ERR_PRE_POWER_FAIL);
		check_value("pre_pwr_on after failure", pre_pwr_on, 0);
		check_value("status bit 31 after failure", fire_status[31], 0);

		// early explode is ignored, then cancel
		@(posedge clk);
		#2;
		pre_pwr_on_ack = 1'b0;
		send_cmd(CMD_PRE_POWER, '0);
		send_cmd(CMD_EXPLODE, 32'h000f_ffff);
		wait_signal(SEL_STATUS, 1'b1, 200, "pre-power success");
		send_cmd(CMD_CANCEL, '0);
		wait_signal(SEL_STATUS, 1'b0, 5, "cancel to clear status bit 31");
		check_value("pre_pwr_on after cancel", pre_pwr_on, 0);
		repeat (40) @(negedge clk);
		exp_status = ref_round(prev_flags, '0);
		-> check_round;
		@(posedge clk);

		for (int r = 0; r < ROUNDS; r++) begin
			seed  = lcg_next(seed);
			param = seed;
			if (param[`FIRE_CHANNELS-1:0] == '0)
				param[0] = 1'b1;
			$display("round %0d mask %05h exp %0d", r, param[`FIRE_CHANNELS-1:0], param[25:24]);
			send_cmd(CMD_PRE_POWER, '0);
			wait_signal(SEL_STATUS, 1'b1, 200, "pre-power success");
			exp_status = ref_round(prev_flags, param[`FIRE_CHANNELS-1:0]);
			send_cmd(CMD_EXPLODE, param);
			wait_signal(SEL_PWR, 1'b0, 6000, "the end of firing");
			-> check_round;
			@(posedge clk);
			prev_flags = exp_status[`FIRE_CHANNELS-1:0];
		end
		finish_run();
	end

endmodule
